//--- logic/priv_cmd_ctrl.sv
`include "tcu_defines.svh"

module priv_cmd_ctrl
    import tcu_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_n_i,

    input  logic         priv_cmd_start_i,
    input  priv_opcode_e priv_cmd_opcode_i,
    input  logic [63:0]  priv_cmd_arg0_i,
    input  logic [63:0]  priv_cmd_arg1_i,

    output tlb_req_t     ctrl_req_o,
    input  logic         ctrl_grant_i,
    input  tlb_rsp_t     ctrl_rsp_i,

    input  logic         priv_reg_stall_i,
    output priv_reg_wr_t priv_reg_wr_o
);

    localparam int status_w = $bits(tcu_error_e) + $bits(priv_opcode_e);

    priv_ctrl_state_e state_q;
    tcu_error_e       error_q;
    tlb_cmd_e         cmd_q;
    tlb_entry_t       entry_q;

    tlb_cmd_e         dec_cmd;
    tlb_entry_t       dec_entry;
    logic             dec_valid;
    logic             fsm_step;

    // ------------------------------
    // opcode decode
    // ------------------------------
    always_comb begin
        dec_cmd   = TLB_CLEAR;
        dec_entry = '0;
        dec_valid = 1'b1;
        case (priv_cmd_opcode_i)
            OP_INV_PAGE: begin
                dec_cmd            = TLB_DELETE;
                dec_entry.vpeid    = priv_cmd_arg0_i[`TCU_VPEID_W-1:0];
                dec_entry.virtpage = priv_cmd_arg1_i[`TCU_PAGE_OFFSET_W +: `TCU_VIRTPAGE_W];
            end
            OP_INV_TLB: begin
                dec_cmd = TLB_CLEAR;
            end
            OP_INS_TLB: begin
                dec_cmd            = TLB_WRITE;
                dec_entry.perm     = priv_cmd_arg0_i[`TCU_PERM_W-1:0];
                dec_entry.physpage = priv_cmd_arg0_i[`TCU_PAGE_OFFSET_W +: `TCU_PHYSPAGE_W];
                dec_entry.virtpage = priv_cmd_arg1_i[`TCU_PAGE_OFFSET_W +: `TCU_VIRTPAGE_W];
                dec_entry.vpeid    = priv_cmd_arg0_i[32 +: `TCU_VPEID_W];
            end
            // idle is not a command either
            default: begin
                dec_valid = 1'b0;
            end
        endcase
    end

    // ------------------------------
    // command sequencing
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            state_q <= S_IDLE;
            error_q <= ERR_NONE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (priv_cmd_start_i) begin
                        state_q <= dec_valid ? S_ISSUE : S_FINISH;
                        error_q <= dec_valid ? ERR_NONE : ERR_UNKNOWN_CMD;
                    end
                end
                S_ISSUE: begin
                    if (ctrl_grant_i) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (ctrl_rsp_i.done) begin
                        error_q <= ctrl_rsp_i.error;
                        state_q <= S_FINISH;
                    end
                end
                S_FINISH: begin
                    if (!priv_reg_stall_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // request captured once per accepted start
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && priv_cmd_start_i) begin
            cmd_q   <= dec_cmd;
            entry_q <= dec_entry;
        end
    end

    always_comb begin
        ctrl_req_o.en    = (state_q == S_ISSUE);
        ctrl_req_o.cmd   = cmd_q;
        ctrl_req_o.entry = entry_q;
    end

    // status word, opcode field back to idle
    always_comb begin
        priv_reg_wr_o.en    = (state_q == S_FINISH);
        priv_reg_wr_o.wben  = '1;
        priv_reg_wr_o.addr  = `TCU_REGADDR_PRIV_CMD;
        priv_reg_wr_o.wdata = {{(`TCU_REG_DATA_W - status_w){1'b0}}, error_q, OP_IDLE};
    end

    assign fsm_step = (state_q == S_ISSUE && ctrl_grant_i) ||
                      (state_q == S_WAIT && ctrl_rsp_i.done) ||
                      (state_q == S_FINISH && !priv_reg_stall_i);

    // a start during a running command must not disturb the sequence
    a_start_ignored: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        (priv_cmd_start_i && state_q != S_IDLE && !fsm_step) |=> $stable(state_q)
    ) else $error("start outside idle changed the command state");

endmodule

//--- logic/tcu_defines.svh
`ifndef TCU_DEFINES_SVH
`define TCU_DEFINES_SVH

// ------------------------------
// TLB entry fields
// ------------------------------
`define TCU_VPEID_W          16
`define TCU_VIRTPAGE_W       20
`define TCU_PHYSPAGE_W       20
`define TCU_PAGE_OFFSET_W    12

// read in bit 0, write in bit 1
`define TCU_PERM_W           2

`define TCU_TLB_DEPTH        8

// ------------------------------
// register interface
// ------------------------------
`define TCU_REG_ADDR_W       8
`define TCU_REG_DATA_W       64

// status word of privileged commands
`define TCU_REGADDR_PRIV_CMD 8'h10

`endif

//--- logic/tcu_pkg.sv
`include "tcu_defines.svh"

package tcu_pkg;

    typedef enum logic [3:0] {
        OP_IDLE     = 4'h0,
        OP_INV_PAGE = 4'h1,
        OP_INV_TLB  = 4'h2,
        OP_INS_TLB  = 4'h3
    } priv_opcode_e;

    typedef enum logic [4:0] {
        ERR_NONE              = 5'd0,
        ERR_UNKNOWN_CMD       = 5'd1,
        ERR_TLB_MISS          = 5'd2,
        ERR_TLB_FULL          = 5'd3,
        ERR_TRANSLATION_FAULT = 5'd4
    } tcu_error_e;

    typedef enum logic [1:0] {
        TLB_READ   = 2'd0,
        TLB_WRITE  = 2'd1,
        TLB_DELETE = 2'd2,
        TLB_CLEAR  = 2'd3
    } tlb_cmd_e;

    typedef struct packed {
        logic [`TCU_PERM_W-1:0]     perm;
        logic [`TCU_PHYSPAGE_W-1:0] physpage;
        logic [`TCU_VIRTPAGE_W-1:0] virtpage;
        logic [`TCU_VPEID_W-1:0]    vpeid;
    } tlb_entry_t;

    typedef struct packed {
        logic       en;
        tlb_cmd_e   cmd;
        tlb_entry_t entry;
    } tlb_req_t;

    typedef struct packed {
        logic       done;
        tcu_error_e error;
        tlb_entry_t entry;
    } tlb_rsp_t;

    typedef struct packed {
        logic                         en;
        logic [`TCU_REG_DATA_W/8-1:0] wben;
        logic [`TCU_REG_ADDR_W-1:0]   addr;
        logic [`TCU_REG_DATA_W-1:0]   wdata;
    } priv_reg_wr_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT,
        S_FINISH
    } priv_ctrl_state_e;

endpackage

//--- logic/tcu_priv_top.sv
`include "tcu_defines.svh"

module tcu_priv_top
    import tcu_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset_n_i,

    input  logic                       priv_cmd_start_i,
    input  priv_opcode_e               priv_cmd_opcode_i,
    input  logic [63:0]                priv_cmd_arg0_i,
    input  logic [63:0]                priv_cmd_arg1_i,

    input  logic                       priv_reg_stall_i,
    output priv_reg_wr_t               priv_reg_wr_o,

    input  logic                       unpriv_tlb_read_i,
    input  logic [`TCU_VPEID_W-1:0]    unpriv_tlb_vpeid_i,
    input  logic [`TCU_VIRTPAGE_W-1:0] unpriv_tlb_virtpage_i,
    input  logic [`TCU_PERM_W-1:0]     unpriv_tlb_read_perm_i,
    output logic [`TCU_PHYSPAGE_W-1:0] unpriv_tlb_physpage_o,
    output logic                       unpriv_tlb_read_done_o,
    output tcu_error_e                 unpriv_tlb_error_o,
    output logic                       unpriv_tlb_active_o
);

    tlb_req_t ctrl_req;
    logic     ctrl_grant;
    tlb_rsp_t ctrl_rsp;
    tlb_req_t store_req;
    tlb_rsp_t store_rsp;

    priv_cmd_ctrl i_priv_cmd_ctrl (
        .clk_i             (clk_i),
        .reset_n_i         (reset_n_i),
        .priv_cmd_start_i  (priv_cmd_start_i),
        .priv_cmd_opcode_i (priv_cmd_opcode_i),
        .priv_cmd_arg0_i   (priv_cmd_arg0_i),
        .priv_cmd_arg1_i   (priv_cmd_arg1_i),
        .ctrl_req_o        (ctrl_req),
        .ctrl_grant_i      (ctrl_grant),
        .ctrl_rsp_i        (ctrl_rsp),
        .priv_reg_stall_i  (priv_reg_stall_i),
        .priv_reg_wr_o     (priv_reg_wr_o)
    );

    tlb_port_arbiter i_tlb_port_arbiter (
        .clk_i                  (clk_i),
        .reset_n_i              (reset_n_i),
        .unpriv_tlb_read_i      (unpriv_tlb_read_i),
        .unpriv_tlb_vpeid_i     (unpriv_tlb_vpeid_i),
        .unpriv_tlb_virtpage_i  (unpriv_tlb_virtpage_i),
        .unpriv_tlb_read_perm_i (unpriv_tlb_read_perm_i),
        .unpriv_tlb_physpage_o  (unpriv_tlb_physpage_o),
        .unpriv_tlb_read_done_o (unpriv_tlb_read_done_o),
        .unpriv_tlb_error_o     (unpriv_tlb_error_o),
        .unpriv_tlb_active_o    (unpriv_tlb_active_o),
        .ctrl_req_i             (ctrl_req),
        .ctrl_grant_o           (ctrl_grant),
        .ctrl_rsp_o             (ctrl_rsp),
        .store_req_o            (store_req),
        .store_rsp_i            (store_rsp)
    );

    tlb_store i_tlb_store (
        .clk_i       (clk_i),
        .reset_n_i   (reset_n_i),
        .store_req_i (store_req),
        .store_rsp_o (store_rsp)
    );

endmodule

//--- logic/tlb_port_arbiter.sv
`include "tcu_defines.svh"

module tlb_port_arbiter
    import tcu_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset_n_i,

    input  logic                       unpriv_tlb_read_i,
    input  logic [`TCU_VPEID_W-1:0]    unpriv_tlb_vpeid_i,
    input  logic [`TCU_VIRTPAGE_W-1:0] unpriv_tlb_virtpage_i,
    input  logic [`TCU_PERM_W-1:0]     unpriv_tlb_read_perm_i,
    output logic [`TCU_PHYSPAGE_W-1:0] unpriv_tlb_physpage_o,
    output logic                       unpriv_tlb_read_done_o,
    output tcu_error_e                 unpriv_tlb_error_o,
    output logic                       unpriv_tlb_active_o,

    input  tlb_req_t                   ctrl_req_i,
    output logic                       ctrl_grant_o,
    output tlb_rsp_t                   ctrl_rsp_o,

    output tlb_req_t                   store_req_o,
    input  tlb_rsp_t                   store_rsp_i
);

    logic       req_en_q;
    tlb_cmd_e   req_cmd_q;
    tlb_entry_t req_entry_q;
    logic       wait_rsp_q;
    logic       owner_priv_q;

    logic       busy;
    logic       grant_unpriv;
    logic       grant_priv;
    tlb_entry_t unpriv_entry;

    // one operation at a time, unprivileged reads first
    assign busy         = req_en_q || wait_rsp_q;
    assign grant_unpriv = !busy && unpriv_tlb_read_i;
    assign grant_priv   = !busy && !unpriv_tlb_read_i && ctrl_req_i.en;
    assign ctrl_grant_o = grant_priv;

    always_comb begin
        unpriv_entry          = '0;
        unpriv_entry.perm     = unpriv_tlb_read_perm_i;
        unpriv_entry.virtpage = unpriv_tlb_virtpage_i;
        unpriv_entry.vpeid    = unpriv_tlb_vpeid_i;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            req_en_q     <= 1'b0;
            wait_rsp_q   <= 1'b0;
            owner_priv_q <= 1'b0;
        end else begin
            req_en_q <= grant_unpriv || grant_priv;
            if (req_en_q) begin
                wait_rsp_q <= 1'b1;
            end else if (store_rsp_i.done) begin
                wait_rsp_q <= 1'b0;
            end
            if (grant_unpriv || grant_priv) begin
                owner_priv_q <= grant_priv;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant_unpriv || grant_priv) begin
            req_cmd_q   <= grant_unpriv ? TLB_READ : ctrl_req_i.cmd;
            req_entry_q <= grant_unpriv ? unpriv_entry : ctrl_req_i.entry;
        end
    end

    always_comb begin
        store_req_o.en    = req_en_q;
        store_req_o.cmd   = req_cmd_q;
        store_req_o.entry = req_entry_q;
    end

    // ------------------------------
    // response routing
    // ------------------------------
    always_comb begin
        ctrl_rsp_o      = store_rsp_i;
        ctrl_rsp_o.done = store_rsp_i.done && owner_priv_q;
    end

    assign unpriv_tlb_read_done_o = store_rsp_i.done && !owner_priv_q;
    assign unpriv_tlb_error_o     = (store_rsp_i.error == ERR_NONE) ? ERR_NONE
                                                                    : ERR_TRANSLATION_FAULT;
    assign unpriv_tlb_physpage_o  = (store_rsp_i.error == ERR_NONE) ? store_rsp_i.entry.physpage
                                                                    : '0;
    assign unpriv_tlb_active_o    = unpriv_tlb_read_i || busy;

    a_no_overlap: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        store_req_o.en |-> !wait_rsp_q
    ) else $error("TLB request issued while previous operation unanswered");

endmodule

//--- logic/tlb_store.sv
`include "tcu_defines.svh"

module tlb_store
    import tcu_pkg::*;
#(
    parameter int depth = `TCU_TLB_DEPTH
) (
    input  logic     clk_i,
    input  logic     reset_n_i,

    input  tlb_req_t store_req_i,
    output tlb_rsp_t store_rsp_o
);

    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

    tlb_entry_t             entries_q [depth];
    logic [depth-1:0]       valid_q;

    logic                   rsp_done_q;
    tcu_error_e             rsp_error_q;
    tlb_entry_t             rsp_entry_q;

    logic                   any_hit;
    logic                   any_free;
    logic [idx_w-1:0]       hit_idx;
    logic [idx_w-1:0]       free_idx;
    logic [idx_w-1:0]       wr_idx;
    logic                   perm_missing;
    logic                   do_write;
    tcu_error_e             rsp_error;
    tlb_entry_t             rsp_entry;

    // ------------------------------
    // parallel match, lowest index wins
    // ------------------------------
    always_comb begin
        any_hit  = 1'b0;
        any_free = 1'b0;
        hit_idx  = '0;
        free_idx = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (valid_q[i] &&
                entries_q[i].vpeid == store_req_i.entry.vpeid &&
                entries_q[i].virtpage == store_req_i.entry.virtpage) begin
                any_hit = 1'b1;
                hit_idx = idx_w'(i);
            end
            if (!valid_q[i]) begin
                any_free = 1'b1;
                free_idx = idx_w'(i);
            end
        end
    end

    assign perm_missing = |(store_req_i.entry.perm & ~entries_q[hit_idx].perm);
    assign wr_idx       = any_hit ? hit_idx : free_idx;
    assign do_write     = store_req_i.en && store_req_i.cmd == TLB_WRITE && (any_hit || any_free);

    always_comb begin
        rsp_error = ERR_NONE;
        rsp_entry = store_req_i.entry;
        case (store_req_i.cmd)
            TLB_READ: begin
                rsp_entry = entries_q[hit_idx];
                if (!any_hit || perm_missing) begin
                    rsp_error = ERR_TLB_MISS;
                end
            end
            TLB_WRITE: begin
                if (!any_hit && !any_free) begin
                    rsp_error = ERR_TLB_FULL;
                end
            end
            TLB_DELETE: begin
                if (!any_hit) begin
                    rsp_error = ERR_TLB_MISS;
                end
            end
            default: begin
                rsp_error = ERR_NONE;
            end
        endcase
    end

    // ------------------------------
    // entry update
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            valid_q    <= '0;
            rsp_done_q <= 1'b0;
        end else begin
            rsp_done_q <= store_req_i.en;
            if (do_write) begin
                valid_q[wr_idx] <= 1'b1;
            end else if (store_req_i.en && store_req_i.cmd == TLB_DELETE && any_hit) begin
                valid_q[hit_idx] <= 1'b0;
            end else if (store_req_i.en && store_req_i.cmd == TLB_CLEAR) begin
                valid_q <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            entries_q[wr_idx] <= store_req_i.entry;
        end
        if (store_req_i.en) begin
            rsp_error_q <= rsp_error;
            rsp_entry_q <= rsp_entry;
        end
    end

    always_comb begin
        store_rsp_o.done  = rsp_done_q;
        store_rsp_o.error = rsp_error_q;
        store_rsp_o.entry = rsp_entry_q;
    end

    a_done_next: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        store_req_i.en |=> store_rsp_o.done
    ) else $error("no done one cycle after TLB request");

endmodule

//--- sources.f
+incdir+logic
logic/tcu_pkg.sv
logic/priv_cmd_ctrl.sv
logic/tlb_port_arbiter.sv
logic/tlb_store.sv
logic/tcu_priv_top.sv
tests/tb_tcu_priv.sv

//--- tests/tb_tcu_priv.sv
`include "tcu_defines.svh"

module tb_tcu_priv
    import tcu_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int depth = `TCU_TLB_DEPTH;

    logic clk_i, reset_n_i, priv_cmd_start_i, priv_reg_stall_i, unpriv_tlb_read_i;
    priv_opcode_e priv_cmd_opcode_i;
    logic [63:0] priv_cmd_arg0_i, priv_cmd_arg1_i;
    priv_reg_wr_t priv_reg_wr_o;
    logic [`TCU_VPEID_W-1:0] unpriv_tlb_vpeid_i;
    logic [`TCU_VIRTPAGE_W-1:0] unpriv_tlb_virtpage_i;
    logic [`TCU_PERM_W-1:0] unpriv_tlb_read_perm_i;
    logic [`TCU_PHYSPAGE_W-1:0] unpriv_tlb_physpage_o;
    logic unpriv_tlb_read_done_o, unpriv_tlb_active_o;
    tcu_error_e unpriv_tlb_error_o;

    logic [31:0] lfsr_q = 32'h1289_212c;
    string cur_test = "none";
    int cmd_count = 0;
    int wr_seen = 0;
    logic [63:0] exp_status_q [$];
    tlb_entry_t model_entry [depth];
    logic [depth-1:0] model_valid;
    logic [15:0] key_vpe [depth+1];
    logic [19:0] key_virt [depth+1];
    logic [19:0] key_phys [depth+1];
    logic [1:0] key_perm [depth+1];

    tcu_priv_top i_tcu_priv_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    // ------------------------------
    // reference TLB model
    // ------------------------------
    function automatic int model_find(input logic [15:0] vpeid, input logic [19:0] virt);
        int idx;
        idx = -1;
        for (int i = depth - 1; i >= 0; i--) begin
            if (model_valid[i] && model_entry[i].vpeid == vpeid &&
                model_entry[i].virtpage == virt) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic tcu_error_e model_apply(input priv_opcode_e op, input logic [63:0] a0,
                                               input logic [63:0] a1);
        tlb_entry_t e;
        int idx;
        e = '0;
        case (op)
            OP_INS_TLB: begin
                e.vpeid    = a0[47:32];
                e.physpage = a0[31:12];
                e.perm     = a0[1:0];
                e.virtpage = a1[31:12];
                idx = model_find(e.vpeid, e.virtpage);
                for (int i = 0; i < depth && idx < 0; i++) begin
                    if (!model_valid[i]) idx = i;
                end
                if (idx < 0) return ERR_TLB_FULL;
                model_entry[idx] = e;
                model_valid[idx] = 1'b1;
                return ERR_NONE;
            end
            OP_INV_PAGE: begin
                idx = model_find(a0[15:0], a1[31:12]);
                if (idx < 0) return ERR_TLB_MISS;
                model_valid[idx] = 1'b0;
                return ERR_NONE;
            end
            OP_INV_TLB: begin
                model_valid = '0;
                return ERR_NONE;
            end
            default: return ERR_UNKNOWN_CMD;
        endcase
    endfunction

    function automatic tcu_error_e model_read(input logic [15:0] vpeid, input logic [19:0] virt,
                                              input logic [1:0] perm, output logic [19:0] phys);
        int idx;
        idx = model_find(vpeid, virt);
        phys = '0;
        if (idx < 0 || |(perm & ~model_entry[idx].perm)) return ERR_TRANSLATION_FAULT;
        phys = model_entry[idx].physpage;
        return ERR_NONE;
    endfunction

    // opcode idle in 3:0, error in 8:4
    function automatic logic [63:0] status_word(input tcu_error_e err);
        logic [63:0] w;
        w = '0;
        w[3:0] = OP_IDLE;
        w[8:4] = err;
        return w;
    endfunction

    // ------------------------------
    // checks and handshakes
    // ------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check(input string what, input logic [63:0] exp_v, input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            fail_run($sformatf("FAILED %s %s: expected %h, actual %h",
                               cur_test, what, exp_v, act_v));
        end
    endtask

    task automatic drive_slot();
        @(posedge clk_i);
        #10;
    endtask

    task automatic start_cmd(input priv_opcode_e op, input logic [63:0] a0,
                             input logic [63:0] a1, input tcu_error_e err);
        exp_status_q.push_back(status_word(err));
        cmd_count++;
        drive_slot();
        priv_cmd_start_i  = 1'b1;
        priv_cmd_opcode_i = op;
        priv_cmd_arg0_i   = a0;
        priv_cmd_arg1_i   = a1;
        drive_slot();
        priv_cmd_start_i = 1'b0;
    endtask

    task automatic wait_writes();
        int n;
        n = 0;
        while (wr_seen < cmd_count && n < 50) begin
            @(posedge clk_i);
            n++;
        end
        if (wr_seen < cmd_count) fail_run("status register write did not arrive in 50 cycles");
    endtask

    task automatic issue_cmd(input priv_opcode_e op, input logic [63:0] a0,
                             input logic [63:0] a1, input tcu_error_e err);
        start_cmd(op, a0, a1, err);
        wait_writes();
    endtask

    task automatic run_cmd(input priv_opcode_e op, input logic [63:0] a0, input logic [63:0] a1);
        issue_cmd(op, a0, a1, model_apply(op, a0, a1));
    endtask

    task automatic insert_key(input int k);
        run_cmd(OP_INS_TLB, {16'h0, key_vpe[k], key_phys[k], 10'h0, key_perm[k]},
                {32'h0, key_virt[k], 12'h0});
    endtask

    task automatic do_read(input logic [15:0] vpeid, input logic [19:0] virt, input logic [1:0] perm,
                           input tcu_error_e exp_err, input logic [19:0] exp_phys);
        logic got;
        int n;
        got = 1'b0;
        drive_slot();
        unpriv_tlb_read_i      = 1'b1;
        unpriv_tlb_vpeid_i     = vpeid;
        unpriv_tlb_virtpage_i  = virt;
        unpriv_tlb_read_perm_i = perm;
        for (n = 0; n < 50 && !got; n++) begin
            @(negedge clk_i);
            if (unpriv_tlb_read_done_o) begin
                got = 1'b1;
                check("read active", 1, unpriv_tlb_active_o);
                check("read error", exp_err, unpriv_tlb_error_o);
                check("read physpage", exp_phys, unpriv_tlb_physpage_o);
            end
        end
        if (!got) fail_run("unprivileged read done did not arrive in 50 cycles");
        drive_slot();
        unpriv_tlb_read_i = 1'b0;
    endtask

    task automatic read_key(input int k, input logic [1:0] perm);
        tcu_error_e err;
        logic [19:0] phys;
        err = model_read(key_vpe[k], key_virt[k], perm, phys);
        do_read(key_vpe[k], key_virt[k], perm, err, phys);
    endtask

    // every accepted status write against the queue of expected words
    initial begin
        forever begin
            @(negedge clk_i);
            if (reset_n_i && priv_reg_wr_o.en && !priv_reg_stall_i) begin
                if (exp_status_q.size() == 0) fail_run("status register written with no command");
                check("status addr", `TCU_REGADDR_PRIV_CMD, priv_reg_wr_o.addr);
                check("status wben", 8'hff, priv_reg_wr_o.wben);
                check("status word", exp_status_q.pop_front(), priv_reg_wr_o.wdata);
                wr_seen++;
            end
        end
    end

    initial begin
        tcu_error_e err;
        tcu_error_e rd_err;
        logic [19:0] rd_phys;
        logic [63:0] a0;
        logic [63:0] a1;
        {reset_n_i, priv_cmd_start_i, priv_reg_stall_i, unpriv_tlb_read_i} = '0;
        {priv_cmd_arg0_i, priv_cmd_arg1_i, unpriv_tlb_vpeid_i, unpriv_tlb_virtpage_i} = '0;
        unpriv_tlb_read_perm_i = '0;
        priv_cmd_opcode_i = OP_IDLE;
        model_valid = '0;
        repeat (4) @(posedge clk_i);
        #10 reset_n_i = 1'b1;
        cur_test = "reset";
        @(negedge clk_i);
        check("reg write en", 0, priv_reg_wr_o.en);
        check("read done", 0, unpriv_tlb_read_done_o);
        check("active", 0, unpriv_tlb_active_o);
        do_read(16'h0001, 20'h00001, 2'b00, ERR_TRANSLATION_FAULT, 20'h0);

        // the last key no longer fits
        for (int i = 0; i <= depth; i++) begin
            cur_test = (i < depth) ? "insert and read" : "tlb full";
            key_vpe[i]  = 16'(take_bits(16));
            key_virt[i] = 20'(take_bits(20));
            key_phys[i] = 20'(take_bits(20));
            key_perm[i] = (i == 0) ? 2'b01 : 2'(take_bits(2));
            insert_key(i);
            read_key(i, 2'b00);
            read_key(i, 2'b11);
        end
        cur_test = "overwrite";
        key_phys[0] = 20'(take_bits(20));
        insert_key(0);
        read_key(0, 2'b01);

        cur_test = "invalidate";
        run_cmd(OP_INV_PAGE, {48'h0, key_vpe[1]}, {32'h0, key_virt[1], 12'h0});
        read_key(1, 2'b00);
        run_cmd(OP_INV_PAGE, {48'h0, key_vpe[1]}, {32'h0, key_virt[1], 12'h0});
        run_cmd(OP_INV_TLB, 64'h0, 64'h0);
        for (int i = 0; i <= depth; i++) read_key(i, 2'b00);

        cur_test = "stalled unknown opcode";
        drive_slot();
        priv_reg_stall_i = 1'b1;
        start_cmd(priv_opcode_e'(4'hA), 64'h0, 64'h0, ERR_UNKNOWN_CMD);
        repeat (6) begin
            @(negedge clk_i);
            check("write pending", 1, priv_reg_wr_o.en);
        end
        drive_slot();
        check("writes under stall", cmd_count - 1, wr_seen);
        priv_reg_stall_i = 1'b0;
        wait_writes();

        cur_test = "read during command";
        insert_key(2);
        rd_err = model_read(key_vpe[2], key_virt[2], 2'b00, rd_phys);
        key_phys[2] = 20'(take_bits(20));
        a0 = {16'h0, key_vpe[2], key_phys[2], 10'h0, key_perm[2]};
        a1 = {32'h0, key_virt[2], 12'h0};
        err = model_apply(OP_INS_TLB, a0, a1);
        fork
            do_read(key_vpe[2], key_virt[2], 2'b00, rd_err, rd_phys);
            issue_cmd(OP_INS_TLB, a0, a1, err);
        join
        read_key(2, 2'b00);

        drive_slot();
        if (wr_seen == cmd_count && exp_status_q.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run("number of status writes differs from number of commands");
        end
    end

endmodule
